/* hdl/stage2_pkg.sv */
`default_nettype none

package stage2_pkg;

    // ========================================================================
    // stage 2 feature map geometry
    // ========================================================================

    // input map, one point per strobe, raster order
    localparam int ST2_POOL_X = 24;
    localparam int ST2_POOL_Y = 24;

    // bits per point
    // signed before relu, bit 18 zero after it
    localparam int ST2_POOL_IBW = 19;

    // 2x2 stride 2 output map
    localparam int ST2_POOL_OX = ST2_POOL_X / 2;
    localparam int ST2_POOL_OY = ST2_POOL_Y / 2;

    // raster counter widths
    localparam int ST2_POOL_COLW = $clog2(ST2_POOL_X);
    localparam int ST2_POOL_ROWW = $clog2(ST2_POOL_Y);

    // pooled points per frame, 144
    localparam int ST2_POOL_OPTS = ST2_POOL_OX * ST2_POOL_OY;

endpackage

`default_nettype wire

/* hdl/stage2_relu.sv */
`timescale 1ns/1ps
`default_nettype none

module stage2_relu (
    input  wire logic                                     clk,
    input  wire logic                                     reset_n,
    input  wire logic                                     i_in_valid,
    input  wire logic signed [stage2_pkg::ST2_POOL_IBW-1:0] i_in_fmap,
    output logic                                          o_relu_valid,
    output logic             [stage2_pkg::ST2_POOL_IBW-1:0] o_relu_fmap
);

    import stage2_pkg::*;

    // ========================================================================
    // strobe, one cycle behind the input
    // ========================================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_relu_valid <= 1'b0;
        end else begin
            o_relu_valid <= i_in_valid;
        end
    end

    // ========================================================================
    // clamp
    // ========================================================================

    // sign bit set means negative, forced to zero
    // holds last value between strobes
    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            if (i_in_fmap[ST2_POOL_IBW-1]) begin
                o_relu_fmap <= '0;
            end else begin
                o_relu_fmap <= i_in_fmap;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/stage2_pooling.sv */
`timescale 1ns/1ps
`default_nettype none

module stage2_pooling (
    input  wire logic                              clk,
    input  wire logic                              reset_n,
    input  wire logic                              i_in_valid,
    input  wire logic [stage2_pkg::ST2_POOL_IBW-1:0] i_in_fmap,
    output logic                                   o_ot_valid,
    output logic      [stage2_pkg::ST2_POOL_IBW-1:0] o_ot_fmap,
    output logic                                   o_ot_last
);

    import stage2_pkg::*;

    // ========================================================================
    // max of two points
    // ========================================================================

    // unsigned compare is safe, relu keeps the top bit clear
    function automatic logic [ST2_POOL_IBW-1:0] max_of_two(
        input logic [ST2_POOL_IBW-1:0] a,
        input logic [ST2_POOL_IBW-1:0] b
    );
        logic [ST2_POOL_IBW-1:0] m;
        if (a > b) begin
            m = a;
        end else begin
            m = b;
        end
        return m;
    endfunction

    // ========================================================================
    // raster position
    // ========================================================================

    // position of the point being presented this cycle
    logic [ST2_POOL_COLW-1:0] col;
    logic [ST2_POOL_ROWW-1:0] row;

    // end of row / end of frame
    logic col_end;
    logic row_end;

    assign col_end = (col == ST2_POOL_COLW'(ST2_POOL_X - 1));
    assign row_end = (row == ST2_POOL_ROWW'(ST2_POOL_Y - 1));

    // advance only on a strobe
    // gaps leave the position untouched
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            col <= '0;
            row <= '0;
        end else if (i_in_valid) begin
            if (col_end) begin
                col <= '0;
                // wrap to row 0 at frame end
                if (row_end) begin
                    row <= '0;
                end else begin
                    row <= row + 1'b1;
                end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // window coordinates in the pooled map
    logic [ST2_POOL_COLW-2:0] ocol;
    logic [ST2_POOL_ROWW-2:0] orow;

    assign ocol = col[ST2_POOL_COLW-1:1];
    assign orow = row[ST2_POOL_ROWW-1:1];

    // odd column closes a horizontal pair
    // even row -> top half of window, odd row -> bottom half
    logic win_top;
    logic win_end;

    assign win_top = i_in_valid & ~row[0] & col[0];
    assign win_end = i_in_valid &  row[0] & col[0];

    // last window of the frame, row 23 col 23
    logic win_last;

    assign win_last = (orow == (ST2_POOL_ROWW - 1)'(ST2_POOL_OY - 1)) &&
                      (ocol == (ST2_POOL_COLW - 1)'(ST2_POOL_OX - 1));

    // ========================================================================
    // horizontal pair
    // ========================================================================

    // previous point of the current row
    // at an odd column this is the even-column partner
    logic [ST2_POOL_IBW-1:0] held_pt;

    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            held_pt <= i_in_fmap;
        end
    end

    // max of the two points in this row of the window
    logic [ST2_POOL_IBW-1:0] pair_max;

    assign pair_max = max_of_two(held_pt, i_in_fmap);

    // ========================================================================
    // half-width line buffer
    // ========================================================================

    // one entry per window column, top row pair max
    logic [ST2_POOL_IBW-1:0] line_buf [ST2_POOL_OX];

    always_ff @(posedge clk) begin
        if (win_top) begin
            line_buf[ocol] <= pair_max;
        end
    end

    // top half of the window now closing
    logic [ST2_POOL_IBW-1:0] top_max;

    assign top_max = line_buf[ocol];

    // ========================================================================
    // output stage
    // ========================================================================

    // window max registered on the bottom-right point
    always_ff @(posedge clk) begin
        if (win_end) begin
            o_ot_fmap <= max_of_two(top_max, pair_max);
        end
    end

    // one-cycle strobe after the bottom-right point
    // never back to back, odd columns only
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_ot_valid <= 1'b0;
            o_ot_last  <= 1'b0;
        end else begin
            o_ot_valid <= win_end;
            o_ot_last  <= win_end & win_last;
        end
    end

endmodule

`default_nettype wire

/* hdl/stage2_pool_top.sv */
`timescale 1ns/1ps
`default_nettype none

module stage2_pool_top (
    input  wire logic                                     clk,
    input  wire logic                                     reset_n,
    input  wire logic                                     i_in_valid,
    input  wire logic signed [stage2_pkg::ST2_POOL_IBW-1:0] i_in_fmap,
    output logic                                          o_ot_valid,
    output logic             [stage2_pkg::ST2_POOL_IBW-1:0] o_ot_fmap,
    output logic                                          o_ot_last
);

    import stage2_pkg::*;

    // ========================================================================
    // relu -> pooling
    // ========================================================================

    // clamped point stream, 1 cycle behind the input
    logic                    relu_valid;
    logic [ST2_POOL_IBW-1:0] relu_fmap;

    // negative convolution points forced to zero
    stage2_relu i_stage2_relu (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_in_valid   (i_in_valid),
        .i_in_fmap    (i_in_fmap),
        .o_relu_valid (relu_valid),
        .o_relu_fmap  (relu_fmap)
    );

    // 24x24 in, 12x12 out
    // output 2 cycles after the raw bottom-right point
    stage2_pooling i_stage2_pooling (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_in_valid (relu_valid),
        .i_in_fmap  (relu_fmap),
        .o_ot_valid (o_ot_valid),
        .o_ot_fmap  (o_ot_fmap),
        .o_ot_last  (o_ot_last)
    );

endmodule

`default_nettype wire

/* test/stage2_pool_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module stage2_pool_properties (
    input  wire logic                                clk,
    input  wire logic                                reset_n,
    input  wire logic                                i_ot_valid,
    input  wire logic [stage2_pkg::ST2_POOL_IBW-1:0] i_ot_fmap,
    input  wire logic                                i_ot_last
);

    import stage2_pkg::*;

    // ========================================================================
    // output strobe rules
    // ========================================================================

    // odd columns only, so never two strobes in a row
    a_valid_spacing: assert property (
        @(posedge clk) disable iff (!reset_n)
        i_ot_valid |=> !i_ot_valid
    ) else $error("o_ot_valid high on two consecutive cycles");

    // last only rides on a real output
    a_last_with_valid: assert property (
        @(posedge clk) disable iff (!reset_n)
        i_ot_last |-> i_ot_valid
    ) else $error("o_ot_last high without o_ot_valid");

    // relu output is never negative
    a_top_bit_clear: assert property (
        @(posedge clk) disable iff (!reset_n)
        i_ot_valid |-> !i_ot_fmap[ST2_POOL_IBW-1]
    ) else $error("o_ot_fmap top bit set on a valid output");

    // outputs quiet in reset
    a_reset_quiet: assert property (
        @(posedge clk)
        !reset_n |-> (!i_ot_valid && !i_ot_last)
    ) else $error("output strobe active during reset");

endmodule

bind stage2_pool_top stage2_pool_properties i_stage2_pool_properties (
    .clk        (clk),
    .reset_n    (reset_n),
    .i_ot_valid (o_ot_valid),
    .i_ot_fmap  (o_ot_fmap),
    .i_ot_last  (o_ot_last)
);

`default_nettype wire

/* test/stage2_pool_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module stage2_pool_tb;

    import stage2_pkg::*;

    // ========================================================================
    // constants and signals
    // ========================================================================

    // raw points per frame
    localparam int NPTS = ST2_POOL_X * ST2_POOL_Y;
    // 6 frames at worst-case gap spacing plus slack
    localparam int MAX_CYCLES = 6 * NPTS * 3 + 500;
    // output trails the raw point by 2 cycles with a few spare
    localparam int DRAIN_CYCLES = 8;

    logic                           clk;
    logic                           reset_n;
    logic                           i_in_valid;
    logic signed [ST2_POOL_IBW-1:0] i_in_fmap;
    logic                           o_ot_valid;
    logic        [ST2_POOL_IBW-1:0] o_ot_fmap;
    logic                           o_ot_last;

    // raw frame in raster order
    logic signed [ST2_POOL_IBW-1:0] frame_pts [NPTS];
    // expected window maxima with the oldest first
    logic [ST2_POOL_IBW-1:0] exp_q [$];

    // updated by the output checker only
    int check_errs = 0;
    int out_total = 0;
    int frame_out = 0;

    // updated by the main sequence only
    int main_errs;
    int tests_passed;
    int tests_failed;
    int cycle_cnt;

    stage2_pool_top i_stage2_pool_top (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_in_valid (i_in_valid),
        .i_in_fmap  (i_in_fmap),
        .o_ot_valid (o_ot_valid),
        .o_ot_fmap  (o_ot_fmap),
        .o_ot_last  (o_ot_last)
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // watchdog
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run stopped after %0d cycles", cycle_cnt);
        $display(">>> FAIL");
        $finish;
    end

    // ========================================================================
    // reference model
    // ========================================================================

    function automatic int relu(input int v);
        return (v < 0) ? 0 : v;
    endfunction

    // clamp then take the max of each 2x2 window in raster order
    function automatic void push_model();
        int m;
        int v;
        for (int wy = 0; wy < ST2_POOL_OY; wy++) begin
            for (int wx = 0; wx < ST2_POOL_OX; wx++) begin
                m = 0;
                for (int dy = 0; dy < 2; dy++) begin
                    for (int dx = 0; dx < 2; dx++) begin
                        v = relu(int'(frame_pts[(2 * wy + dy) * ST2_POOL_X + 2 * wx + dx]));
                        if (v > m) begin
                            m = v;
                        end
                    end
                end
                exp_q.push_back(ST2_POOL_IBW'(m));
            end
        end
    endfunction

    // full 19-bit random of either sign
    function automatic void fill_random();
        for (int i = 0; i < NPTS; i++) begin
            frame_pts[i] = ST2_POOL_IBW'($urandom);
        end
    endfunction

    // -1 down to the most negative value
    function automatic void fill_negative();
        for (int i = 0; i < NPTS; i++) begin
            frame_pts[i] = ST2_POOL_IBW'(-1 - int'($urandom_range(262143, 0)));
        end
    endfunction

    // one large point per window with its position rotating across windows
    function automatic void fill_sweep();
        int win;
        int pos;
        for (int i = 0; i < NPTS; i++) begin
            win = ((i / ST2_POOL_X) / 2) * ST2_POOL_OX + (i % ST2_POOL_X) / 2;
            pos = ((i / ST2_POOL_X) % 2) * 2 + (i % ST2_POOL_X) % 2;
            if (pos == win % 4) begin
                frame_pts[i] = ST2_POOL_IBW'(200000 + win);
            end else begin
                frame_pts[i] = ST2_POOL_IBW'($urandom_range(1000, 0));
            end
        end
    endfunction

    // ========================================================================
    // output checker
    // ========================================================================

    // sampled mid-cycle away from the DUT's clock edge
    always @(negedge clk) begin : check_output
        logic [ST2_POOL_IBW-1:0] exp_val;
        logic                    exp_last;
        if (!reset_n) begin
            // reset drops everything still expected
            exp_q.delete();
            frame_out = 0;
        end else if (o_ot_valid) begin
            exp_last = (frame_out == ST2_POOL_OPTS - 1);
            assert (exp_q.size() > 0) else begin
                $display("error: output strobe at %0t ns with no expected value left", $time);
                check_errs++;
            end
            if (exp_q.size() > 0) begin
                exp_val = exp_q.pop_front();
                assert (o_ot_fmap == exp_val) else begin
                    $display("[FAIL] %0t ns o_ot_fmap expected %0d got %0d",
                             $time, exp_val, o_ot_fmap);
                    check_errs++;
                end
            end
            assert (o_ot_last == exp_last) else begin
                $display("[FAIL] %0t ns o_ot_last expected %0b got %0b",
                         $time, exp_last, o_ot_last);
                check_errs++;
            end
            frame_out = (frame_out == ST2_POOL_OPTS - 1) ? 0 : frame_out + 1;
            out_total++;
        end
    end

    // ========================================================================
    // stimulus
    // ========================================================================

    function automatic int total_errs();
        return check_errs + main_errs;
    endfunction

    task automatic drive_point(input logic signed [ST2_POOL_IBW-1:0] v);
        @(posedge clk);
        #2;
        i_in_valid = 1'b1;
        i_in_fmap  = v;
    endtask

    // junk on the data lines is ignored without a strobe
    task automatic drive_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            i_in_valid = 1'b0;
            i_in_fmap  = ST2_POOL_IBW'($urandom);
        end
    endtask

    task automatic drive_frame(input int gap_max);
        for (int i = 0; i < NPTS; i++) begin
            if (gap_max > 0) begin
                drive_idle(int'($urandom_range(gap_max, 0)));
            end
            drive_point(frame_pts[i]);
        end
    endtask

    // wait for the queue to empty and then check the output count
    task automatic finish_test(input string name, input int exp_outputs,
                               input int out_base, input int err_base);
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < DRAIN_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        // a few more cycles to catch stray strobes
        drive_idle(3);
        assert (exp_q.size() == 0) else begin
            $display("error: %s ended with %0d expected outputs missing", name, exp_q.size());
            main_errs++;
        end
        assert (out_total - out_base == exp_outputs) else begin
            $display("[FAIL] %0t ns output count expected %0d got %0d",
                     $time, exp_outputs, out_total - out_base);
            main_errs++;
        end
        if (total_errs() == err_base) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed", name);
        end
    endtask

    initial begin
        int err_base;
        int out_base;
        void'($urandom(32'hf0950ab0));
        reset_n      = 1'b1;
        i_in_valid   = 1'b0;
        i_in_fmap    = '0;
        main_errs    = 0;
        tests_passed = 0;
        tests_failed = 0;
        #1;
        reset_n = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        reset_n = 1'b1;

        // continuous random frame
        err_base = total_errs();
        out_base = out_total;
        fill_random();
        push_model();
        drive_frame(0);
        drive_idle(1);
        finish_test("continuous random", ST2_POOL_OPTS, out_base, err_base);

        // 0 to 3 idle cycles between points
        err_base = total_errs();
        out_base = out_total;
        fill_random();
        push_model();
        drive_frame(3);
        drive_idle(1);
        finish_test("gapped strobes", ST2_POOL_OPTS, out_base, err_base);

        // every output zero from the relu clamp
        err_base = total_errs();
        out_base = out_total;
        fill_negative();
        push_model();
        drive_frame(0);
        drive_idle(1);
        finish_test("all negative", ST2_POOL_OPTS, out_base, err_base);

        // large point at each window position in turn
        err_base = total_errs();
        out_base = out_total;
        fill_sweep();
        push_model();
        drive_frame(0);
        drive_idle(1);
        finish_test("position sweep", ST2_POOL_OPTS, out_base, err_base);

        // second frame starts the cycle after the first ends
        err_base = total_errs();
        out_base = out_total;
        fill_random();
        push_model();
        drive_frame(0);
        fill_random();
        push_model();
        drive_frame(0);
        drive_idle(1);
        finish_test("back-to-back frames", 2 * ST2_POOL_OPTS, out_base, err_base);

        // reset at row 13 while the strobe for the window ending at col 11 is out
        // the point at col 12 is still inside the relu stage
        err_base = total_errs();
        fill_random();
        push_model();
        for (int i = 0; i < 325; i++) begin
            drive_point(frame_pts[i]);
        end
        @(posedge clk);
        #2;
        reset_n    = 1'b0;
        i_in_valid = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        reset_n  = 1'b1;
        out_base = out_total;
        fill_random();
        push_model();
        drive_frame(0);
        drive_idle(1);
        finish_test("reset mid-frame", ST2_POOL_OPTS, out_base, err_base);

        $display("tests passed: %0d, failed: %0d, errors: %0d",
                 tests_passed, tests_failed, total_errs());
        if (tests_failed == 0 && total_errs() == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* stage2_pool.f */
hdl/stage2_pkg.sv
hdl/stage2_relu.sv
hdl/stage2_pooling.sv
hdl/stage2_pool_top.sv
test/stage2_pool_properties.sv
test/stage2_pool_tb.sv

/* Makefile */
# Verilator simulation of the stage 2 pooling path
# any variable below can be set on the command line

VERILATOR ?= verilator
TOP       ?= stage2_pool_tb
FILELIST  ?= stage2_pool.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= >>> FAIL
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q '$(FAIL_MSG)' $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
